// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcacheTb
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+src
src/dcachePkg.sv
src/cacheArray.sv
src/refillBuffer.sv
src/storeMerge.sv
src/cacheController.sv
src/dcacheTop.sv
verification/busMemModel.sv
verification/dcacheTb.sv

// File: src/cacheArray.sv
`timescale 1ns/1ns
`include "dcacheDefs.svh"

module cacheArray
  import dcachePkg::*;
#(
  parameter type entryT = logic [7:0]
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wrEn_i,
  input  indexT wrIndex_i,
  input  entryT wrEntry_i,
  input  indexT rdIndex_i,
  output entryT rdEntry_o
);

  entryT mem [`SETS];

  // cleared on reset so valid and dirty bits start at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `SETS; i++) begin
        mem[i] <= '0;
      end
    end else if (wrEn_i) begin
      mem[wrIndex_i] <= wrEntry_i;
    end
  end

  // register file style read, no latency
  assign rdEntry_o = mem[rdIndex_i];

  // write index comes from the controller's request latch
  assert property (@(posedge clk) disable iff (!rst_n) wrEn_i |-> !$isunknown(wrIndex_i));

endmodule

// File: src/cacheController.sv
`timescale 1ns/1ns
`include "dcacheDefs.svh"

module cacheController
  import dcachePkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // pipeline request
  input  logic                 reqValid_i,
  input  logic                 reqWrite_i,
  input  addrT                 reqAddr_i,
  input  wordT                 wrData_i,
  input  maskT                 wrMask_i,
  // array read data at the latched index
  input  tagEntryT             way0Tag_i,
  input  tagEntryT             way1Tag_i,
  input  lineT                 way0Line_i,
  input  lineT                 way1Line_i,
  input  lineT                 refillLine_i,
  input  lineT                 mergedLine_i,
  // bus status
  input  logic                 busRdReady_i,
  input  logic                 busRdLast_i,
  input  logic                 busWrReady_i,
  // pipeline response
  output logic                 addrOk_o,
  output logic                 dataOk_o,
  output wordT                 rdData_o,
  // array write control
  output indexT                index_o,
  output logic [1:0]           tagWrEn_o,
  output logic [1:0]           dataWrEn_o,
  output tagEntryT             tagEntry_o,
  output lineT                 dataLine_o,
  // refill and store merge
  output logic                 collect_o,
  output lineT                 baseLine_o,
  output logic [`OFFSET_W-1:0] byteOffset_o,
  output wordT                 storeData_o,
  output maskT                 storeMask_o,
  // bus requests
  output logic                 rdReqValid_o,
  output addrT                 rdAddr_o,
  output logic                 wrReqValid_o,
  output addrT                 wrAddr_o,
  output lineT                 wrLine_o
);

  cacheStateT curState;
  cacheStateT nextState;

  logic     reqWriteQ;
  addrT     reqAddrQ;
  wordT     wrDataQ;
  maskT     wrMaskQ;

  tagT      reqTag;
  indexT    reqIndex;
  logic [`OFFSET_W-`WORD_SEL_LSB-1:0] wordSel;

  logic     inCompare;
  logic     way0Hit;
  logic     way1Hit;
  logic     hit;
  logic     accept;
  logic     replWay;
  tagEntryT victimEntry;
  lineT     victimLine;
  lineT     hitLine;

  // address fields of the latched request
  assign reqTag   = reqAddrQ[`ADDR_W-1 -: `TAG_W];
  assign reqIndex = reqAddrQ[`OFFSET_W +: `INDEX_W];
  assign wordSel  = reqAddrQ[`OFFSET_W-1:`WORD_SEL_LSB];

  assign inCompare = (curState == compare);
  assign way0Hit   = way0Tag_i.valid && (way0Tag_i.tag == reqTag);
  assign way1Hit   = way1Tag_i.valid && (way1Tag_i.tag == reqTag);
  assign hit       = way0Hit || way1Hit;

  // a new request may enter while the current one hits
  assign addrOk_o = (curState == idle) || (inCompare && hit);
  assign accept   = reqValid_i && addrOk_o;
  assign dataOk_o = inCompare && hit;

  assign hitLine  = way1Hit ? way1Line_i : way0Line_i;
  assign rdData_o = hitLine[wordSel*`XLEN +: `XLEN];

  // victim way follows the replacement bit
  assign victimEntry = replWay ? way1Tag_i : way0Tag_i;
  assign victimLine  = replWay ? way1Line_i : way0Line_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= idle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      idle: begin
        if (accept) begin
          nextState = compare;
        end
      end
      compare: begin
        if (hit) begin
          nextState = accept ? compare : idle;
        end else if (victimEntry.valid && victimEntry.dirty) begin
          nextState = writeBack;
        end else begin
          nextState = refillReq;
        end
      end
      writeBack: begin
        if (busWrReady_i) begin
          nextState = refillReq;
        end
      end
      refillReq: begin
        if (busRdReady_i) begin
          nextState = getData;
        end
      end
      getData: begin
        if (busRdLast_i) begin
          nextState = replace;
        end
      end
      replace: begin
        nextState = compare;
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  // request latch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqWriteQ <= 1'b0;
    end else if (accept) begin
      reqWriteQ <= reqWrite_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddrQ <= reqAddr_i;
      wrDataQ  <= wrData_i;
      wrMaskQ  <= wrMask_i;
    end
  end

  // toggles once per refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      replWay <= 1'b0;
    end else if (curState == replace) begin
      replWay <= ~replWay;
    end
  end

  // store hit writes the hit way, refill writes the victim way
  always_comb begin
    tagWrEn_o  = 2'b00;
    dataWrEn_o = 2'b00;
    if (inCompare && hit && reqWriteQ) begin
      tagWrEn_o  = {way1Hit, way0Hit};
      dataWrEn_o = {way1Hit, way0Hit};
    end else if (curState == replace) begin
      tagWrEn_o  = replWay ? 2'b10 : 2'b01;
      dataWrEn_o = replWay ? 2'b10 : 2'b01;
    end
  end

  // dirty only when a store lands in the line
  assign tagEntry_o = '{valid: 1'b1, dirty: reqWriteQ, tag: reqTag};
  assign dataLine_o = reqWriteQ ? mergedLine_i : refillLine_i;
  assign index_o    = reqIndex;

  assign collect_o    = (curState == getData);
  assign baseLine_o   = (curState == replace) ? refillLine_i : hitLine;
  assign byteOffset_o = reqAddrQ[`OFFSET_W-1:0];
  assign storeData_o  = wrDataQ;
  assign storeMask_o  = wrMaskQ;

  // line-aligned bus addresses
  assign rdReqValid_o = (curState == refillReq);
  assign rdAddr_o     = {reqTag, reqIndex, {`OFFSET_W{1'b0}}};
  assign wrReqValid_o = (curState == writeBack);
  assign wrAddr_o     = {victimEntry.tag, reqIndex, {`OFFSET_W{1'b0}}};
  assign wrLine_o     = victimLine;

  assert property (@(posedge clk) disable iff (!rst_n) !(rdReqValid_o && wrReqValid_o));

  assert property (@(posedge clk) disable iff (!rst_n) dataOk_o |-> curState == compare);

endmodule

// File: src/dcacheDefs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address and pipeline word
`define ADDR_W        32
`define XLEN          64
`define MASK_W        8

// cache geometry
`define LINE_W        256
`define SETS          64
`define INDEX_W       6
`define OFFSET_W      5
`define TAG_W         21

// refill burst length in words
`define BEATS         4

// lowest address bit of the word select field
`define WORD_SEL_LSB  3

`endif

// File: src/dcachePkg.sv
`include "dcacheDefs.svh"

package dcachePkg;

  typedef logic [`ADDR_W-1:0]  addrT;
  typedef logic [`XLEN-1:0]    wordT;
  typedef logic [`MASK_W-1:0]  maskT;
  typedef logic [`LINE_W-1:0]  lineT;
  typedef logic [`TAG_W-1:0]   tagT;
  typedef logic [`INDEX_W-1:0] indexT;

  // one tag array entry per way and set
  typedef struct packed {
    logic valid;
    logic dirty;
    tagT  tag;
  } tagEntryT;

  typedef enum logic [2:0] {
    idle,
    compare,
    writeBack,
    refillReq,
    getData,
    replace
  } cacheStateT;

endpackage

// File: src/dcacheTop.sv
`timescale 1ns/1ns
`include "dcacheDefs.svh"

module dcacheTop
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  // pipeline side
  input  logic reqValid_i,
  input  logic reqWrite_i,
  input  addrT reqAddr_i,
  input  wordT wrData_i,
  input  maskT wrMask_i,
  output logic addrOk_o,
  output logic dataOk_o,
  output wordT rdData_o,
  // bus read side
  output logic rdReqValid_o,
  output addrT rdAddr_o,
  input  logic busRdReady_i,
  input  logic busDataValid_i,
  input  wordT busRdData_i,
  input  logic busRdLast_i,
  // bus write side
  output logic wrReqValid_o,
  output addrT wrAddr_o,
  output lineT wrLine_o,
  input  logic busWrReady_i
);

  tagEntryT             way0Tag;
  tagEntryT             way1Tag;
  lineT                 way0Line;
  lineT                 way1Line;
  lineT                 refillLine;
  lineT                 mergedLine;
  indexT                index;
  logic [1:0]           tagWrEn;
  logic [1:0]           dataWrEn;
  tagEntryT             tagEntry;
  lineT                 dataLine;
  logic                 collect;
  lineT                 baseLine;
  logic [`OFFSET_W-1:0] byteOffset;
  wordT                 storeData;
  maskT                 storeMask;

  cacheController uCtrl (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .reqWrite_i(reqWrite_i), .reqAddr_i(reqAddr_i),
    .wrData_i(wrData_i), .wrMask_i(wrMask_i),
    .way0Tag_i(way0Tag), .way1Tag_i(way1Tag),
    .way0Line_i(way0Line), .way1Line_i(way1Line),
    .refillLine_i(refillLine), .mergedLine_i(mergedLine),
    .busRdReady_i(busRdReady_i), .busRdLast_i(busRdLast_i), .busWrReady_i(busWrReady_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .rdData_o(rdData_o),
    .index_o(index), .tagWrEn_o(tagWrEn), .dataWrEn_o(dataWrEn),
    .tagEntry_o(tagEntry), .dataLine_o(dataLine),
    .collect_o(collect), .baseLine_o(baseLine), .byteOffset_o(byteOffset),
    .storeData_o(storeData), .storeMask_o(storeMask),
    .rdReqValid_o(rdReqValid_o), .rdAddr_o(rdAddr_o),
    .wrReqValid_o(wrReqValid_o), .wrAddr_o(wrAddr_o), .wrLine_o(wrLine_o)
  );

  refillBuffer uRefill (
    .clk(clk), .rst_n(rst_n), .collect_i(collect),
    .beatValid_i(busDataValid_i), .beatLast_i(busRdLast_i), .beatData_i(busRdData_i),
    .line_o(refillLine)
  );

  storeMerge uMerge (
    .baseLine_i(baseLine), .byteOffset_i(byteOffset),
    .storeData_i(storeData), .storeMask_i(storeMask), .merged_o(mergedLine)
  );

  // tag arrays, one per way
  cacheArray #(.entryT(tagEntryT)) uTag0 (
    .clk(clk), .rst_n(rst_n), .wrEn_i(tagWrEn[0]), .wrIndex_i(index),
    .wrEntry_i(tagEntry), .rdIndex_i(index), .rdEntry_o(way0Tag)
  );

  cacheArray #(.entryT(tagEntryT)) uTag1 (
    .clk(clk), .rst_n(rst_n), .wrEn_i(tagWrEn[1]), .wrIndex_i(index),
    .wrEntry_i(tagEntry), .rdIndex_i(index), .rdEntry_o(way1Tag)
  );

  // data arrays, whole line per entry
  cacheArray #(.entryT(lineT)) uData0 (
    .clk(clk), .rst_n(rst_n), .wrEn_i(dataWrEn[0]), .wrIndex_i(index),
    .wrEntry_i(dataLine), .rdIndex_i(index), .rdEntry_o(way0Line)
  );

  cacheArray #(.entryT(lineT)) uData1 (
    .clk(clk), .rst_n(rst_n), .wrEn_i(dataWrEn[1]), .wrIndex_i(index),
    .wrEntry_i(dataLine), .rdIndex_i(index), .rdEntry_o(way1Line)
  );

endmodule

// File: src/refillBuffer.sv
`timescale 1ns/1ns
`include "dcacheDefs.svh"

module refillBuffer
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic collect_i,
  input  logic beatValid_i,
  input  logic beatLast_i,
  input  wordT beatData_i,
  output lineT line_o
);

  logic [$clog2(`BEATS)-1:0] beatCnt;
  lineT                      lineQ;

  // beat counter, restarts for every burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (!collect_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // beat i lands in word i of the line
  always_ff @(posedge clk) begin
    if (collect_i && beatValid_i) begin
      lineQ[beatCnt*`XLEN +: `XLEN] <= beatData_i;
    end
  end

  assign line_o = lineQ;

  // bus must only send beats while the controller waits for data
  assert property (@(posedge clk) disable iff (!rst_n) beatValid_i |-> collect_i);

  // last flag marks exactly the fourth beat of the burst
  assert property (@(posedge clk) disable iff (!rst_n)
    beatLast_i == (beatValid_i && beatCnt == 2'd3));

endmodule

// File: src/storeMerge.sv
`timescale 1ns/1ns
`include "dcacheDefs.svh"

module storeMerge
  import dcachePkg::*;
(
  input  lineT                 baseLine_i,
  input  logic [`OFFSET_W-1:0] byteOffset_i,
  input  wordT                 storeData_i,
  input  maskT                 storeMask_i,
  output lineT                 merged_o
);

  logic [`OFFSET_W-`WORD_SEL_LSB-1:0] wordSel;
  logic [`WORD_SEL_LSB-1:0]           inByte;
  wordT                               shiftedData;
  maskT                               shiftedMask;
  wordT                               bitEn;
  wordT                               baseWord;

  assign wordSel = byteOffset_i[`OFFSET_W-1:`WORD_SEL_LSB];
  assign inByte  = byteOffset_i[`WORD_SEL_LSB-1:0];

  // move right-aligned data up to its byte offset, upper bytes fall off
  assign shiftedData = storeData_i << {inByte, 3'b000};
  assign shiftedMask = storeMask_i << inByte;

  // one enable bit per data bit
  always_comb begin
    for (int b = 0; b < `MASK_W; b++) begin
      bitEn[b*8 +: 8] = {8{shiftedMask[b]}};
    end
  end

  assign baseWord = baseLine_i[wordSel*`XLEN +: `XLEN];

  always_comb begin
    merged_o = baseLine_i;
    merged_o[wordSel*`XLEN +: `XLEN] = (baseWord & ~bitEn) | (shiftedData & bitEn);
  end

endmodule

// File: verification/busMemModel.sv
`timescale 1ns/1ns
`include "dcacheDefs.svh"

module busMemModel
  import dcachePkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic rdReqValid_i,
  input  addrT rdAddr_i,
  output logic busRdReady_o,
  output logic busDataValid_o,
  output wordT busRdData_o,
  output logic busRdLast_o,
  input  logic wrReqValid_i,
  input  addrT wrAddr_i,
  input  lineT wrLine_i,
  output logic busWrReady_o
);

  // sparse store, untouched bytes come from the fill pattern
  logic [7:0] mem [addrT];
  addrT       burstAddr;
  int         beatNum;
  int         rdWait;
  int         wrWait;

  function automatic logic [7:0] fillByte(addrT a);
    return a[7:0] ^ (a[15:8] + 8'h3c) ^ a[23:16] ^ a[31:24];
  endfunction

  function automatic logic [7:0] readByte(addrT a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fillByte(a);
  endfunction

  initial begin
    busRdReady_o   = 1'b0;
    busDataValid_o = 1'b0;
    busRdData_o    = '0;
    busRdLast_o    = 1'b0;
    busWrReady_o   = 1'b0;
    beatNum        = -1;
    rdWait         = -1;
    wrWait         = -1;
    forever begin
      @(posedge clk);
      #2;
      busRdReady_o   = 1'b0;
      busWrReady_o   = 1'b0;
      busDataValid_o = 1'b0;
      busRdLast_o    = 1'b0;
      if (!rst_n) begin
        beatNum = -1;
      end else if (beatNum >= 0) begin
        // one beat per cycle once the read was granted
        for (int i = 0; i < 8; i++) begin
          busRdData_o[i*8 +: 8] = readByte(burstAddr + 32'(beatNum * 8 + i));
        end
        busDataValid_o = 1'b1;
        busRdLast_o    = (beatNum == `BEATS - 1);
        beatNum        = (beatNum == `BEATS - 1) ? -1 : beatNum + 1;
      end else if (wrReqValid_i) begin
        if (wrWait < 0) begin
          wrWait = $urandom_range(0, 3);
        end
        if (wrWait == 0) begin
          busWrReady_o = 1'b1;
          for (int i = 0; i < `LINE_W / 8; i++) begin
            mem[wrAddr_i + 32'(i)] = wrLine_i[i*8 +: 8];
          end
        end
        wrWait = wrWait - 1;
      end else if (rdReqValid_i) begin
        if (rdWait < 0) begin
          rdWait = $urandom_range(0, 3);
        end
        if (rdWait == 0) begin
          busRdReady_o = 1'b1;
          burstAddr    = rdAddr_i;
          beatNum      = 0;
        end
        rdWait = rdWait - 1;
      end
    end
  end

endmodule

// File: verification/dcacheTb.sv
`timescale 1ns/1ns
`include "dcacheDefs.svh"

module dcacheTb
  import dcachePkg::*;
;

  // directed accesses plus the random mix
  localparam int DirectedOps = 11;
  localparam int RandomOps = 400;
  localparam int NumOps = DirectedOps + RandomOps;
  localparam int CycleLimit = NumOps * 40;

  logic clk, rst_n;
  logic reqValid, reqWrite, addrOk, dataOk;
  addrT reqAddr, rdAddr, wrAddr;
  wordT wrData, rdData, busRdData;
  maskT wrMask;
  logic rdReqValid, busRdReady, busDataValid, busRdLast, wrReqValid, busWrReady;
  lineT wrLine;
  int   cycleCount;

  // reference byte image, tag copy and replacement bit
  logic [7:0] image [addrT];
  logic       tbValid [2][`SETS];
  logic       tbDirty [2][`SETS];
  tagT        tbTag [2][`SETS];
  logic       tbRepl;

  dcacheTop UUT (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqWrite_i(reqWrite), .reqAddr_i(reqAddr),
    .wrData_i(wrData), .wrMask_i(wrMask),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .rdReqValid_o(rdReqValid), .rdAddr_o(rdAddr), .busRdReady_i(busRdReady),
    .busDataValid_i(busDataValid), .busRdData_i(busRdData), .busRdLast_i(busRdLast),
    .wrReqValid_o(wrReqValid), .wrAddr_o(wrAddr), .wrLine_o(wrLine),
    .busWrReady_i(busWrReady)
  );

  busMemModel uMem (
    .clk(clk), .rst_n(rst_n),
    .rdReqValid_i(rdReqValid), .rdAddr_i(rdAddr), .busRdReady_o(busRdReady),
    .busDataValid_o(busDataValid), .busRdData_o(busRdData), .busRdLast_o(busRdLast),
    .wrReqValid_i(wrReqValid), .wrAddr_i(wrAddr), .wrLine_i(wrLine),
    .busWrReady_o(busWrReady)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > CycleLimit) begin
      $display("TESTS FAILED");
      $fatal(1, "simulation ran past %0d cycles without finishing", CycleLimit);
    end
  end

  function automatic logic [7:0] imageByte(addrT a);
    if (image.exists(a)) begin
      return image[a];
    end
    return a[7:0] ^ (a[15:8] + 8'h3c) ^ a[23:16] ^ a[31:24];
  endfunction

  // expected load word and expected line content from the byte image
  function automatic wordT refWord(addrT a);
    wordT w;
    for (int i = 0; i < 8; i++) begin
      w[i*8 +: 8] = imageByte({a[31:3], 3'b000} + 32'(i));
    end
    return w;
  endfunction

  function automatic lineT refLine(addrT lineAddr);
    lineT l;
    for (int i = 0; i < `LINE_W / 8; i++) begin
      l[i*8 +: 8] = imageByte(lineAddr + 32'(i));
    end
    return l;
  endfunction

  task automatic applyStore(addrT a, wordT data, maskT mask);
    for (int k = 0; k < 8; k++) begin
      if (mask[k] && (int'(a[2:0]) + k) < 8) begin
        image[a + 32'(k)] = data[k*8 +: 8];
      end
    end
  endtask

  task automatic reportFailure(string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic checkWord(string name, wordT exp, wordT act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      reportFailure("load word mismatch");
    end
  endtask

  task automatic checkLine(string name, lineT exp, lineT act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      reportFailure("write-back line mismatch");
    end
  endtask

  task automatic checkAddr(string name, addrT exp, addrT act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      reportFailure("bus address mismatch");
    end
  endtask

  // one request and its bus traffic up to the dataOk pulse
  task automatic access(string name, logic wr, addrT a, wordT data, maskT mask);
    indexT idx;
    tagT   tg;
    int    way;
    logic  expWb;
    addrT  wbAddr;
    lineT  wbLine;
    int    cycles;
    int    wbCount;
    int    rdCount;
    idx   = a[`OFFSET_W +: `INDEX_W];
    tg    = a[`ADDR_W-1 -: `TAG_W];
    way   = -1;
    expWb = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (tbValid[w][idx] && tbTag[w][idx] == tg) begin
        way = w;
      end
    end
    if (way < 0) begin
      way    = tbRepl ? 1 : 0;
      expWb  = tbValid[way][idx] && tbDirty[way][idx];
      wbAddr = {tbTag[way][idx], idx, {`OFFSET_W{1'b0}}};
      wbLine = refLine(wbAddr);
      tbValid[way][idx] = 1'b1;
      tbDirty[way][idx] = 1'b0;
      tbTag[way][idx]   = tg;
      tbRepl = ~tbRepl;
      cycles = -1;
    end else begin
      cycles = 0;
    end
    if (wr) begin
      tbDirty[way][idx] = 1'b1;
      applyStore(a, data, mask);
    end
    @(posedge clk);
    #2;
    reqValid = 1'b1;
    reqWrite = wr;
    reqAddr  = a;
    wrData   = data;
    wrMask   = mask;
    do begin
      @(negedge clk);
    end while (!addrOk);
    @(posedge clk);
    #2;
    reqValid = 1'b0;
    wbCount  = 0;
    rdCount  = 0;
    do begin
      @(negedge clk);
      if (cycles >= 0) begin
        cycles++;
      end
      if (wrReqValid && busWrReady) begin
        checkAddr({name, " wb addr"}, wbAddr, wrAddr);
        checkLine({name, " wb line"}, wbLine, wrLine);
        wbCount++;
      end
      if (rdReqValid && busRdReady) begin
        checkAddr({name, " refill addr"}, {a[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}}, rdAddr);
        rdCount++;
      end
    end while (!dataOk);
    if (cycles > 1) begin
      reportFailure({name, ": hit did not answer one cycle after acceptance"});
    end
    if (wbCount != (expWb ? 1 : 0)) begin
      reportFailure({name, ": write-back count differs from the predicted victim"});
    end
    if (rdCount != ((cycles < 0) ? 1 : 0)) begin
      reportFailure({name, ": refill count differs from the predicted hit or miss"});
    end
    if (!wr) begin
      checkWord(name, refWord(a), rdData);
    end
  endtask

  // two loads to a resident line with the second accepted during the first hit
  task automatic pairLoads(string name, addrT a, addrT b);
    @(posedge clk);
    #2;
    reqValid = 1'b1;
    reqWrite = 1'b0;
    reqAddr  = a;
    do begin
      @(negedge clk);
    end while (!addrOk);
    @(posedge clk);
    #2;
    reqAddr = b;
    @(negedge clk);
    if (!dataOk || !addrOk) begin
      reportFailure({name, ": first load did not hit with the next request accepted"});
    end
    checkWord({name, " first"}, refWord(a), rdData);
    @(posedge clk);
    #2;
    reqValid = 1'b0;
    @(negedge clk);
    if (!dataOk) begin
      reportFailure({name, ": second load gave no result one cycle later"});
    end
    checkWord({name, " second"}, refWord(b), rdData);
  endtask

  initial begin
    addrT a;
    void'($urandom(32'hb068_8e53));
    cycleCount = 0;
    rst_n    = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr  = '0;
    wrData   = '0;
    wrMask   = '0;
    tbRepl   = 1'b0;
    for (int s = 0; s < `SETS; s++) begin
      for (int w = 0; w < 2; w++) begin
        tbValid[w][s] = 1'b0;
        tbDirty[w][s] = 1'b0;
        tbTag[w][s]   = '0;
      end
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    if (!addrOk || dataOk || rdReqValid || wrReqValid) begin
      reportFailure("outputs after reset are not in their idle levels");
    end

    access("first load miss", 1'b0, 32'h0000_100b, '0, '0);
    pairLoads("back to back hits", 32'h0000_1000, 32'h0000_1018);
    access("store hit", 1'b1, 32'h0000_1013, 64'h1122_3344_5566_7788, 8'h35);
    access("load after store hit", 1'b0, 32'h0000_1010, '0, '0);
    access("store miss", 1'b1, 32'h0000_2045, 64'h99aa_bbcc_ddee_ff01, 8'h0b);
    access("load after store miss", 1'b0, 32'h0000_2040, '0, '0);

    // set 10 with a dirty victim first and then a clean one
    access("fill way dirty", 1'b1, 32'h0000_0948, 64'hcafe_f00d_1234_5678, 8'hff);
    access("fill way clean", 1'b0, 32'h0000_1148, '0, '0);
    access("evict dirty", 1'b0, 32'h0000_1950, '0, '0);
    access("evict clean", 1'b0, 32'h0000_2158, '0, '0);

    for (int n = 0; n < RandomOps; n++) begin
      a = {21'($urandom_range(8, 11)), 6'($urandom_range(0, 3)), 5'($urandom_range(0, 31))};
      if ($urandom_range(0, 1) == 1) begin
        access("random store", 1'b1, a, {$urandom, $urandom}, 8'($urandom_range(1, 255)));
      end else begin
        access("random load", 1'b0, a, '0, '0);
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule
